/* sources.f */
stepper_pkg.sv
motion_cfg_if.sv
spi_slave.sv
spi_word_assembler.sv
command_decoder.sv
step_rate_gen.sv
phase_driver.sv
stepper_top.sv
stepper_asserts.sv
stepper_tb.sv

/* stepper_tb.sv */
module stepper_tb import stepper_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  logic CLK;
  logic rst;
  logic sck;
  logic ssel;
  logic mosi;
  logic miso;
  logic phase_a1;
  logic phase_a2;
  logic phase_b1;
  logic phase_b2;
  logic pwm_a;
  logic pwm_b;
  logic step;
  logic dir;
  logic busy;
  logic led;

  integer            seed;
  logic [word_w-1:0] last_word;  // Expected echo in the next frame
  logic              led_model;
  logic [pos_w-1:0]  pos_model;
  int                exp_model;
  int                cycle_no;
  int                busy_rise_at;
  int                busy_fall_at;
  logic              busy_prev;
  int                step_at [$];  // Cycle numbers of step pulses

  stepper_top i_dut (.*);

  bind stepper_top stepper_asserts u_asserts (
    .CLK (CLK), .rst (rst), .step (step), .busy (busy),
    .phase_a1 (phase_a1), .phase_a2 (phase_a2),
    .phase_b1 (phase_b1), .phase_b2 (phase_b2)
  );

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  // Step monitor, sampled on the falling edge
  initial begin
    cycle_no  = 0;
    busy_prev = 1'b0;
    forever begin
      @(negedge CLK);
      cycle_no++;
      if (busy && !busy_prev)
        busy_rise_at = cycle_no;
      if (!busy && busy_prev)
        busy_fall_at = cycle_no;
      busy_prev = busy;
      if (step)
        step_at.push_back(cycle_no);
    end
  end

  function automatic int step_period(input int d);
    return d + 1;
  endfunction

  function automatic logic [pos_w-1:0] next_position(input logic [pos_w-1:0] p,
      input logic up, input int e, input int n);
    int delta;
    delta = (n << (3 - e)) % 32;  // 2**(3-e) positions per step
    return up ? p + delta : p - delta;
  endfunction

  // Pins in the order a1, a2, b1, b2
  function automatic logic [3:0] expected_pins(input logic [pos_w-1:0] p);
    logic a_pos;
    logic b_pos;
    a_pos = (p[4:3] == 2'd0) || (p[4:3] == 2'd3);
    b_pos = (p[4:3] < 2'd2);
    return {a_pos, !a_pos, b_pos, !b_pos};
  endfunction

  function automatic int expected_mag(input logic [pos_w-1:0] p, input logic phase_b);
    int k;
    k = p[2:0];
    if (p[3] ^ phase_b)
      return sine_lut[k];
    else
      return sine_lut[8 - k];
  endfunction

  function automatic cmd_word_u move_word(input logic up, input int n);
    cmd_word_u w;
    w.mv.opcode = op_move;
    w.mv.dir    = up;
    w.mv.count  = count_w'(n);
    return w;
  endfunction

  function automatic cmd_word_u setting_word(input logic [7:0] op, input int value);
    cmd_word_u w;
    w.set.opcode = op;
    w.set.value  = divisor_w'(value);
    return w;
  endfunction

  task automatic check(input string what, input logic [31:0] expected,
      input logic [31:0] actual);
    if (actual !== expected) begin
      $display("Error at %0t ns: %s expected %0h, got %0h", $time, what, expected, actual);
      $display("test failed");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  task automatic wait_busy_low(input int limit);
    int waited;
    waited = 0;
    while (busy) begin
      if (waited == limit) begin
        $display("Timeout: busy still high after %0d cycles", limit);
        $display("test failed");
        $fatal(1, "Wait for the end of a move expired");
      end
      @(negedge CLK);
      waited++;
    end
  endtask

  // SPI mode 0 host, SCK at CLK/10, MSB first, low byte first
  task automatic spi_transfer(input logic [word_w-1:0] word, output logic [word_w-1:0] reply);
    logic [7:0] tx;
    logic [7:0] rx;
    @(negedge CLK);
    ssel = 1'b0;
    repeat (5) @(negedge CLK);
    for (int b = 0; b < 4; b++) begin
      tx = word[8*b +: 8];
      for (int i = 7; i >= 0; i--) begin
        sck  = 1'b0;
        mosi = tx[i];
        repeat (5) @(negedge CLK);
        rx[i] = miso;  // Just before the rising edge
        sck   = 1'b1;
        repeat (5) @(negedge CLK);
      end
      reply[8*b +: 8] = rx;
    end
    sck = 1'b0;
    repeat (5) @(negedge CLK);
    ssel = 1'b1;
    repeat (4) @(negedge CLK);
  endtask

  task automatic send_command(input logic [word_w-1:0] word);
    logic [word_w-1:0] reply;
    spi_transfer(word, reply);
    check("SPI reply", last_word, reply);
    last_word = word;
    led_model = ~led_model;  // Any word toggles it
    check("led", led_model, led);
  endtask

  task automatic start_move(input logic up, input int n);
    step_at.delete();
    busy_rise_at = -1;
    busy_fall_at = -1;
    send_command(move_word(up, n));
  endtask

  task automatic finish_move(input logic up, input int n, input int d);
    wait_busy_low((d + 1) * (n + 1) + 50);
    @(negedge CLK);  // Monitor has logged the fall by now
    check("step count", n, step_at.size());
    // busy rises one cycle after move_start
    check("first step delay", step_period(d) - 1, step_at[0] - busy_rise_at);
    for (int i = 1; i < n; i++)
      check("step gap", step_period(d), step_at[i] - step_at[i - 1]);
    check("dir", up, dir);
    check("busy fall after last step", 1, busy_fall_at - step_at[n - 1]);
    pos_model = next_position(pos_model, up, exp_model, n);
  endtask

  task automatic check_outputs();
    int high_a;
    int high_b;
    high_a = 0;
    high_b = 0;
    repeat (3) @(negedge CLK);  // Position, phase and PWM registers settle
    check("phase pins", expected_pins(pos_model), {phase_a1, phase_a2, phase_b1, phase_b2});
    repeat (256) begin
      @(negedge CLK);
      high_a += pwm_a;
      high_b += pwm_b;
    end
    check("pwm_a duty", expected_mag(pos_model, 1'b0), high_a);
    check("pwm_b duty", expected_mag(pos_model, 1'b1), high_b);
  endtask

  initial begin
    logic [word_w-1:0] w;
    int                d;
    int                n;
    logic              up;
    seed      = 32'h708ec771;
    rst       = 1'b1;
    sck       = 1'b0;
    ssel      = 1'b1;
    mosi      = 1'b0;
    last_word = '0;
    led_model = 1'b0;
    pos_model = '0;
    exp_model = 0;
    repeat (7) @(negedge CLK);
    // step busy miso led pwm_a pwm_b a1 a2 b1 b2 dir
    check("reset state", 11'b000000_1010_0,
          {step, busy, miso, led, pwm_a, pwm_b, phase_a1, phase_a2, phase_b1, phase_b2, dir});
    @(negedge CLK);
    rst = 1'b0;
    repeat (4) @(negedge CLK);

    repeat (4) begin
      w     = $random(seed);
      w[31] = 1'b1;  // Opcodes from 128 up do nothing
      send_command(w);
    end

    d  = 1 + $unsigned($random(seed)) % 8;
    n  = 1 + $unsigned($random(seed)) % 8;
    up = 1'($random(seed));
    send_command(setting_word(op_rate, d));
    start_move(up, n);
    finish_move(up, n, d);

    send_command(setting_word(op_rate, 2));
    for (int e = 0; e <= 3; e++) begin
      send_command(setting_word(op_microstep, e));
      exp_model = e;
      for (int k = 0; k < 2; k++) begin
        n = 1 + $unsigned($random(seed)) % 8;
        start_move(1'(k), n);
        finish_move(1'(k), n, 2);
        check_outputs();
      end
    end

    send_command(setting_word(op_rate, 99));
    send_command(setting_word(op_microstep, 6));
    exp_model = 3;  // Saturates at the largest exponent
    start_move(1'b0, 1);
    finish_move(1'b0, 1, 99);
    check_outputs();

    send_command(setting_word(op_microstep, 0));
    send_command(setting_word(op_microstep, 7));
    start_move(1'b1, 6);
    check("busy before second move", 1, busy);
    send_command(move_word(1'b0, 5));
    check("busy after second move", 1, busy);
    finish_move(1'b1, 6, 99);
    check_outputs();

    repeat (4) @(negedge CLK);
    if (i_dut.u_asserts.violations == 0) begin
      $display("test passed");
      $finish;
    end else begin
      $display("test failed");
      $fatal(1, "Bound assertions reported %0d violations", i_dut.u_asserts.violations);
    end
  end

endmodule

/* stepper_asserts.sv */
module stepper_asserts (
  input logic CLK,
  input logic rst,
  input logic step,
  input logic busy,
  input logic phase_a1,
  input logic phase_a2,
  input logic phase_b1,
  input logic phase_b2
);
  timeunit 1ns;
  timeprecision 100ps;

  int violations = 0;  // Read by the testbench at the end

  single_step: assert property (@(posedge CLK) disable iff (rst) step |=> !step)
    else begin
      violations++;
      $error("step stayed high for two cycles");
    end

  // H-bridge pins of one phase never drive the same level
  bridge_pairs: assert property (@(posedge CLK) disable iff (rst)
    (phase_a1 != phase_a2) && (phase_b1 != phase_b2))
    else begin
      violations++;
      $error("phase pin pair not complementary");
    end

  step_in_move: assert property (@(posedge CLK) disable iff (rst) step |-> busy)
    else begin
      violations++;
      $error("step pulse while busy is low");
    end

endmodule

/* stepper_top.sv */
module stepper_top import stepper_pkg::*; (
  input  logic CLK,
  input  logic rst,
  input  logic sck,
  input  logic ssel,  // Active low
  input  logic mosi,
  output logic miso,
  output logic phase_a1,
  output logic phase_a2,
  output logic phase_b1,
  output logic phase_b2,
  output logic pwm_a,
  output logic pwm_b,
  output logic step,
  output logic dir,
  output logic busy,
  output logic led
);

  logic [7:0]        byte_data;
  logic              byte_strobe;
  logic              frame_start;
  logic [7:0]        reply_byte;
  logic [word_w-1:0] word_data;
  logic              word_strobe;

  motion_cfg_if cfg_bus ();

  spi_slave u_spi (
    .CLK, .rst, .sck, .ssel, .mosi, .miso,
    .reply_byte, .byte_data, .byte_strobe, .frame_start
  );

  spi_word_assembler u_words (
    .CLK, .rst, .byte_data, .byte_strobe, .frame_start,
    .word_data, .word_strobe, .reply_byte
  );

  command_decoder u_decode (
    .CLK, .rst, .word_data, .word_strobe, .busy, .led,
    .cfg (cfg_bus.cfg_src)
  );

  step_rate_gen u_rate (
    .CLK, .rst, .cfg (cfg_bus.cfg_dst), .step, .dir, .busy
  );

  phase_driver u_phase (
    .CLK, .rst, .step, .dir,
    .ustep_exp (cfg_bus.ustep_exp),
    .phase_a1, .phase_a2, .phase_b1, .phase_b2, .pwm_a, .pwm_b
  );

endmodule

/* phase_driver.sv */
module phase_driver import stepper_pkg::*; (
  input  logic               CLK,
  input  logic               rst,
  input  logic               step,
  input  logic               dir,
  input  logic [ustep_w-1:0] ustep_exp,
  output logic               phase_a1,
  output logic               phase_a2,
  output logic               phase_b1,
  output logic               phase_b2,
  output logic               pwm_a,
  output logic               pwm_b
);

  logic [pos_w-1:0] pos;
  logic [pos_w-1:0] step_size;
  logic [1:0]       quad;
  logic [2:0]       k;
  logic [3:0]       k_rev;
  logic [pwm_w-1:0] mag_a;
  logic [pwm_w-1:0] mag_b;
  logic [pwm_w-1:0] mag_a_q;
  logic [pwm_w-1:0] mag_b_q;
  logic             a_pos;
  logic             b_pos;
  logic [pwm_w-1:0] pwm_cnt;

  // Full step is 8 positions, finest microstep is 1
  assign step_size = pos_w'(1) << (ustep_max - ustep_exp);

  assign quad  = pos[4:3];
  assign k     = pos[2:0];
  assign k_rev = 4'd8 - {1'b0, k};

  // A follows cosine, B follows sine
  assign mag_b = quad[0] ? sine_lut[k_rev] : sine_lut[k];
  assign mag_a = quad[0] ? sine_lut[k] : sine_lut[k_rev];
  assign a_pos = ~(quad[1] ^ quad[0]);  // Quadrants 0 and 3
  assign b_pos = ~quad[1];               // Quadrants 0 and 1

  always_ff @(posedge CLK) begin
    if (rst) begin
      pos <= '0;
    end else if (step) begin
      if (dir)
        pos <= pos + step_size;  // Wraps at 32
      else
        pos <= pos - step_size;
    end
  end

  always_ff @(posedge CLK) begin
    mag_a_q <= mag_a;
    mag_b_q <= mag_b;
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      phase_a1 <= 1'b1;
      phase_a2 <= 1'b0;
      phase_b1 <= 1'b1;
      phase_b2 <= 1'b0;
      pwm_cnt  <= '0;
      pwm_a    <= 1'b0;
      pwm_b    <= 1'b0;
    end else begin
      phase_a1 <= a_pos;
      phase_a2 <= ~a_pos;
      phase_b1 <= b_pos;
      phase_b2 <= ~b_pos;
      pwm_cnt  <= pwm_cnt + 1'b1;  // Free running
      pwm_a    <= (pwm_cnt < mag_a_q);
      pwm_b    <= (pwm_cnt < mag_b_q);
    end
  end

endmodule

/* step_rate_gen.sv */
module step_rate_gen import stepper_pkg::*; (
  input  logic          CLK,
  input  logic          rst,
  motion_cfg_if.cfg_dst cfg,
  output logic          step,
  output logic          dir,
  output logic          busy
);

  logic [divisor_w-1:0] acc;
  logic [count_w-1:0]   remaining;
  logic [count_w-1:0]   left;
  logic                 active;
  logic                 tick;

  // A new move counts from the start pulse itself
  assign left   = cfg.move_start ? cfg.move_count : remaining;
  assign active = cfg.move_start | (busy & (remaining != '0));
  assign tick   = active & (acc >= cfg.divisor);  // Live divisor

  always_ff @(posedge CLK) begin
    if (rst) begin
      step      <= 1'b0;
      dir       <= 1'b0;
      busy      <= 1'b0;
      acc       <= '0;
      remaining <= '0;
    end else begin
      step <= 1'b0;
      if (cfg.move_start) begin
        dir  <= cfg.move_dir;
        busy <= 1'b1;
      end

      if (active) begin
        remaining <= left;
        if (tick) begin
          step      <= 1'b1;
          acc       <= '0;
          remaining <= left - 1'b1;
        end else begin
          acc <= acc + 1'b1;
        end
      end else if (busy) begin
        busy <= 1'b0;  // Last pulse just went out
      end
    end
  end

endmodule

/* command_decoder.sv */
module command_decoder import stepper_pkg::*; (
  input  logic              CLK,
  input  logic              rst,
  input  logic [word_w-1:0] word_data,
  input  logic              word_strobe,
  input  logic              busy,
  output logic              led,
  motion_cfg_if.cfg_src     cfg
);

  cmd_word_u          cmd;
  logic [ustep_w-1:0] ustep_clamped;

  assign cmd = word_data;

  // Only powers of two are possible, large exponents saturate
  assign ustep_clamped = (cmd.set.value > divisor_w'(ustep_max)) ?
                         ustep_max : cmd.set.value[ustep_w-1:0];

  always_ff @(posedge CLK) begin
    if (rst) begin
      led            <= 1'b0;
      cfg.divisor    <= divisor_reset;
      cfg.ustep_exp  <= '0;  // Full steps
      cfg.move_dir   <= 1'b0;
      cfg.move_count <= '0;
      cfg.move_start <= 1'b0;
    end else begin
      cfg.move_start <= 1'b0;
      if (word_strobe) begin
        led <= ~led;  // Every word, known opcode or not
        case (cmd.set.opcode)
          op_move: begin
            cfg.move_dir   <= cmd.mv.dir;
            cfg.move_count <= cmd.mv.count;
            // Dropped while a move is running
            if (!busy && cmd.mv.count != '0)
              cfg.move_start <= 1'b1;
          end
          op_rate: begin
            cfg.divisor <= cmd.set.value;
          end
          op_microstep: begin
            cfg.ustep_exp <= ustep_clamped;
          end
          default: ;
        endcase
      end
    end
  end

endmodule

/* spi_word_assembler.sv */
module spi_word_assembler import stepper_pkg::*; (
  input  logic              CLK,
  input  logic              rst,
  input  logic [7:0]        byte_data,
  input  logic              byte_strobe,
  input  logic              frame_start,
  output logic [word_w-1:0] word_data,
  output logic              word_strobe,
  output logic [7:0]        reply_byte
);

  logic [1:0]        byte_idx;
  logic [1:0]        reply_idx;
  logic [word_w-1:0] partial;

  // Little endian, first byte lands in bits 7..0
  always_ff @(posedge CLK) begin
    if (byte_strobe)
      partial[8*byte_idx +: 8] <= byte_data;
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      byte_idx    <= '0;
      word_strobe <= 1'b0;
      word_data   <= '0;  // Reply in the first frame
    end else begin
      word_strobe <= 1'b0;
      if (frame_start) begin
        byte_idx <= '0;
      end else if (byte_strobe) begin
        byte_idx <= byte_idx + 2'd1;
        if (byte_idx == 2'd3) begin
          word_data   <= {byte_data, partial[23:0]};
          word_strobe <= 1'b1;
        end
      end
    end
  end

  // Echo of the last complete word, low byte first
  always_ff @(posedge CLK) begin
    if (rst)
      reply_idx <= '0;
    else if (frame_start)
      reply_idx <= '0;
    else if (byte_strobe)
      reply_idx <= reply_idx + 2'd1;
  end

  assign reply_byte = word_data[8*reply_idx +: 8];

endmodule

/* spi_slave.sv */
module spi_slave (
  input  logic       CLK,
  input  logic       rst,
  input  logic       sck,
  input  logic       ssel,
  input  logic       mosi,
  input  logic [7:0] reply_byte,
  output logic       miso,
  output logic [7:0] byte_data,
  output logic       byte_strobe,
  output logic       frame_start
);

  logic [2:0] sck_q;   // Two sync stages plus one for edge detect
  logic [2:0] ssel_q;
  logic [1:0] mosi_q;
  logic       sck_rise;
  logic       sck_fall;
  logic       ssel_fall;
  logic [2:0] bit_cnt;
  logic [6:0] rx_shift;
  logic [6:0] tx_shift;

  assign sck_rise  = sck_q[1] & ~sck_q[2];
  assign sck_fall  = ~sck_q[1] & sck_q[2];
  assign ssel_fall = ~ssel_q[1] & ssel_q[2];

  always_ff @(posedge CLK) begin
    if (rst) begin
      sck_q  <= '0;
      ssel_q <= '1;  // Deselected
      mosi_q <= '0;
    end else begin
      sck_q  <= {sck_q[1:0], sck};
      ssel_q <= {ssel_q[1:0], ssel};
      mosi_q <= {mosi_q[0], mosi};
    end
  end

  // Receive side, MSB first on rising SCK
  always_ff @(posedge CLK) begin
    if (rst) begin
      bit_cnt     <= '0;
      byte_strobe <= 1'b0;
      frame_start <= 1'b0;
    end else begin
      byte_strobe <= 1'b0;
      frame_start <= ssel_fall;
      if (ssel_q[1]) begin
        bit_cnt <= '0;  // Idle between frames
      end else if (sck_rise) begin
        bit_cnt     <= bit_cnt + 3'd1;
        byte_strobe <= (bit_cnt == 3'd7);
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (!ssel_q[1] && sck_rise) begin
      rx_shift <= {rx_shift[5:0], mosi_q[1]};
      if (bit_cnt == 3'd7)
        byte_data <= {rx_shift, mosi_q[1]};
    end
  end

  // Transmit side, next bit on falling SCK
  always_ff @(posedge CLK) begin
    if (rst) begin
      miso     <= 1'b0;
      tx_shift <= '0;
    end else if (frame_start) begin
      miso     <= reply_byte[7];  // First reply bit ahead of the first clock
      tx_shift <= reply_byte[6:0];
    end else if (!ssel_q[1] && sck_fall) begin
      if (bit_cnt == 3'd0) begin  // Byte boundary, fetch the next reply byte
        miso     <= reply_byte[7];
        tx_shift <= reply_byte[6:0];
      end else begin
        miso     <= tx_shift[6];
        tx_shift <= {tx_shift[5:0], 1'b0};
      end
    end
  end

endmodule

/* motion_cfg_if.sv */
interface motion_cfg_if import stepper_pkg::*; ();

  logic [divisor_w-1:0] divisor;
  logic [ustep_w-1:0]   ustep_exp;
  logic                 move_dir;
  logic [count_w-1:0]   move_count;
  logic                 move_start;  // One cycle pulse

  // Decoder side
  modport cfg_src (
    output divisor, ustep_exp, move_dir, move_count, move_start
  );

  // Step engine side
  modport cfg_dst (
    input divisor, ustep_exp, move_dir, move_count, move_start
  );

endinterface

/* stepper_pkg.sv */
package stepper_pkg;

  // Opcodes live in bits 31..24 of a command word
  localparam logic [7:0] op_move      = 8'd1;
  localparam logic [7:0] op_rate      = 8'd3;
  localparam logic [7:0] op_microstep = 8'd4;

  localparam int word_w    = 32;
  localparam int count_w   = 23;  // Move length in steps
  localparam int divisor_w = 24;
  localparam int ustep_w   = 2;   // Microstep exponent
  localparam int pos_w     = 5;   // One electrical cycle
  localparam int pwm_w     = 8;

  localparam logic [ustep_w-1:0]   ustep_max     = 2'd3;  // 8 microsteps per step
  localparam logic [divisor_w-1:0] divisor_reset = 24'd50000;

  // Quarter sine in eighths, both ends included
  localparam int sine_n = 9;
  localparam logic [pwm_w-1:0] sine_lut [sine_n] = '{
    8'd0, 8'd50, 8'd98, 8'd142, 8'd180, 8'd212, 8'd236, 8'd250, 8'd255
  };

  // One command word, read as a move or as a setting
  typedef union packed {
    struct packed {
      logic [7:0]         opcode;
      logic               dir;
      logic [count_w-1:0] count;
    } mv;
    struct packed {
      logic [7:0]           opcode;
      logic [divisor_w-1:0] value;  // Divisor, or exponent in low bits
    } set;
  } cmd_word_u;

endpackage
